// ==== flist.f ====
hdl/erx_pkg.sv
hdl/erx_cfg.sv
hdl/erx_protocol.sv
hdl/erx_remap.sv
hdl/erx_top.sv
verif/erx_checker.sv
verif/tb_erx.sv

// ==== hdl/erx_cfg.sv ====
`timescale 1ns/1ps

module erx_cfg import erx_pkg::*;
(
   input  logic       rx_lclk_div4,
   input  logic       reset,
   input  logic       rx_enable,
   input  logic       cfg_write,
   input  logic [1:0] cfg_addr,
   input  chip_id_t   cfg_data,
   output logic       rx_enable_sync,
   output chip_id_t   chip_id,
   output chip_id_t   remap_mask,
   output chip_id_t   remap_pattern
);

   logic enable_meta;   // First synchronizer flop

   // Enable pin comes from another clock domain
   always_ff @(posedge rx_lclk_div4 or posedge reset)
   begin
      if (reset)
      begin
         enable_meta    <= 1'b0;
         rx_enable_sync <= 1'b0;
      end
      else
      begin
         enable_meta    <= rx_enable;
         rx_enable_sync <= enable_meta;
      end
   end

   // ##############################
   // Remap control registers
   // ##############################
   always_ff @(posedge rx_lclk_div4 or posedge reset)
   begin
      if (reset)
      begin
         chip_id       <= '0;
         remap_mask    <= '0;
         remap_pattern <= '0;
      end
      else if (cfg_write)
      begin
         case (cfg_addr)
            CFG_CHIP_ID:       chip_id       <= cfg_data;
            CFG_REMAP_MASK:    remap_mask    <= cfg_data;
            CFG_REMAP_PATTERN: remap_pattern <= cfg_data;
            default: ;   // Address 3 not mapped
         endcase
      end
   end

   a_cfg_addr_known: assert property (@(posedge rx_lclk_div4) disable iff (reset)
      cfg_write |-> !$isunknown(cfg_addr));

endmodule

// ==== hdl/erx_pkg.sv ====
package erx_pkg;

   // ##############################
   // Transaction field types
   // ##############################
   typedef logic [31:0] addr_t;        // Destination and source address
   typedef logic [31:0] data_t;
   typedef logic [3:0]  ctrl_t;        // Control mode
   typedef logic [1:0]  dmode_t;       // Data mode
   typedef logic [11:0] chip_id_t;     // Compared against dstaddr[31:20]

   // Parallel link side, one byte per lane, lane 7 first in time
   typedef logic [7:0]  lane_frame_t;
   typedef logic [63:0] lane_data_t;
   typedef logic [2:0]  align_t;       // Lane index of the frame edge

   // ##############################
   // Output packet layout
   // ##############################
   localparam int PACKET_W = 104;
   typedef logic [PACKET_W-1:0] packet_t;

   localparam int PKT_WRITE_BIT = 0;
   localparam int PKT_DMODE_LSB = 1;   // Bits 2:1
   localparam int PKT_CTRL_LSB  = 3;   // Bits 6:3
   localparam int PKT_RSVD_BIT  = 7;   // Always zero
   localparam int PKT_DST_LSB   = 8;
   localparam int PKT_DATA_LSB  = 40;
   localparam int PKT_SRC_LSB   = 72;

   // Address step between stream beats
   localparam addr_t STREAM_STEP = 32'd8;

   // Configuration register addresses
   localparam logic [1:0] CFG_CHIP_ID       = 2'd0;
   localparam logic [1:0] CFG_REMAP_MASK    = 2'd1;
   localparam logic [1:0] CFG_REMAP_PATTERN = 2'd2;

endpackage

// ==== hdl/erx_protocol.sv ====
`timescale 1ns/1ps

module erx_protocol import erx_pkg::*;
(
   input  logic        rx_lclk_div4,
   input  logic        reset,
   input  logic        rx_enable_sync,
   input  lane_frame_t rx_frame_par,
   input  lane_data_t  rx_data_par,
   output logic        dec_access,
   output logic        dec_write,
   output dmode_t      dec_datamode,
   output ctrl_t       dec_ctrlmode,
   output addr_t       dec_dstaddr,
   output data_t       dec_data,
   output addr_t       dec_srcaddr
);

   lane_frame_t  lane_edge;      // Rising edge per lane
   logic         edge_found;
   align_t       edge_lane;
   logic         frame_prev;     // Lane 0 frame bit of the previous group

   logic         active_in;
   align_t       align_in;
   lane_data_t   data_in;

   // Stage 0
   logic         active_0;
   align_t       align_0;
   logic         stream_0;
   ctrl_t        ctrlmode_0;
   addr_t        dstaddr_0;
   dmode_t       datamode_0;
   logic         write_0;
   logic         access_0;
   logic [31:16] data_0;

   // Stage 1
   logic         active_1;
   align_t       align_1;
   logic         stream_1;
   ctrl_t        ctrlmode_1;
   addr_t        dstaddr_1;
   dmode_t       datamode_1;
   logic         write_1;
   logic         access_1;
   data_t        data_1;
   addr_t        srcaddr_1;

   logic         access_reg;
   logic         stream_reg;

   // ##############################
   // Frame edge detection
   // ##############################
   assign lane_edge = rx_frame_par & ~{frame_prev, rx_frame_par[7:1]};

   // Ascending scan so the highest lane wins
   always_comb
   begin
      edge_found = 1'b0;
      edge_lane  = '0;
      for (int i = 0; i < 8; i++)
      begin
         if (lane_edge[i])
         begin
            edge_found = 1'b1;
            edge_lane  = align_t'(i);
         end
      end
   end

   always_ff @(posedge rx_lclk_div4 or posedge reset)
   begin
      if (reset)
      begin
         frame_prev <= 1'b0;
         active_in  <= 1'b0;
         align_in   <= '0;
      end
      else
      begin
         frame_prev <= rx_frame_par[0];
         active_in  <= edge_found;
         if (edge_found)
            align_in <= edge_lane;   // Held through stream beats
      end
   end

   always_ff @(posedge rx_lclk_div4)
      data_in <= rx_data_par;

   // ##############################
   // Stage 0, header group
   // ##############################
   always_ff @(posedge rx_lclk_div4 or posedge reset)
   begin
      if (reset)
      begin
         active_0 <= 1'b0;
         align_0  <= '0;
         stream_0 <= 1'b0;
      end
      else
      begin
         active_0 <= active_in;
         align_0  <= align_in;
         // Lane 1 of the group on the inputs carries byte 14
         stream_0 <= (align_in == 3'd7) & rx_frame_par[1] & (active_in | stream_0);
      end
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      case (align_in)
         3'd7:
         begin
            ctrlmode_0 <= data_in[55:52];
            dstaddr_0  <= data_in[51:20];
            datamode_0 <= data_in[19:18];
            write_0    <= data_in[17];
            access_0   <= data_in[16];
            data_0     <= data_in[15:0];
         end
         3'd6:
         begin
            ctrlmode_0    <= data_in[47:44];
            dstaddr_0     <= data_in[43:12];
            datamode_0    <= data_in[11:10];
            write_0       <= data_in[9];
            access_0      <= data_in[8];
            data_0[31:24] <= data_in[7:0];
         end
         3'd5:
         begin
            ctrlmode_0 <= data_in[39:36];
            dstaddr_0  <= data_in[35:4];
            datamode_0 <= data_in[3:2];
            write_0    <= data_in[1];
            access_0   <= data_in[0];
         end
         3'd4:
         begin
            ctrlmode_0      <= data_in[31:28];
            dstaddr_0[31:4] <= data_in[27:0];
         end
         3'd3:
         begin
            ctrlmode_0       <= data_in[23:20];
            dstaddr_0[31:12] <= data_in[19:0];
         end
         3'd2:
         begin
            ctrlmode_0       <= data_in[15:12];
            dstaddr_0[31:20] <= data_in[11:0];
         end
         3'd1:
         begin
            ctrlmode_0       <= data_in[7:4];
            dstaddr_0[31:28] <= data_in[3:0];
         end
         default: ;   // Only the header byte here
      endcase
   end

   // ##############################
   // Stage 1, second group
   // ##############################
   always_ff @(posedge rx_lclk_div4 or posedge reset)
   begin
      if (reset)
      begin
         active_1 <= 1'b0;
         align_1  <= '0;
         stream_1 <= 1'b0;
      end
      else
      begin
         active_1 <= active_0;
         align_1  <= align_0;
         stream_1 <= stream_0;
      end
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      ctrlmode_1    <= ctrlmode_0;
      dstaddr_1     <= dstaddr_0;
      datamode_1    <= datamode_0;
      write_1       <= write_0;
      access_1      <= access_0;
      data_1[31:16] <= data_0;
      case (align_0)
         3'd7:
         begin
            data_1[15:0] <= data_in[63:48];
            srcaddr_1    <= data_in[47:16];
         end
         3'd6:
         begin
            data_1[23:0] <= data_in[63:40];
            srcaddr_1    <= data_in[39:8];
         end
         3'd5:
         begin
            data_1    <= data_in[63:32];
            srcaddr_1 <= data_in[31:0];
         end
         3'd4:
         begin
            dstaddr_1[3:0]  <= data_in[63:60];
            datamode_1      <= data_in[59:58];
            write_1         <= data_in[57];
            access_1        <= data_in[56];
            data_1          <= data_in[55:24];
            srcaddr_1[31:8] <= data_in[23:0];
         end
         3'd3:
         begin
            dstaddr_1[11:0]  <= data_in[63:52];
            datamode_1       <= data_in[51:50];
            write_1          <= data_in[49];
            access_1         <= data_in[48];
            data_1           <= data_in[47:16];
            srcaddr_1[31:16] <= data_in[15:0];
         end
         3'd2:
         begin
            dstaddr_1[19:0]  <= data_in[63:44];
            datamode_1       <= data_in[43:42];
            write_1          <= data_in[41];
            access_1         <= data_in[40];
            data_1           <= data_in[39:8];
            srcaddr_1[31:24] <= data_in[7:0];
         end
         3'd1:
         begin
            dstaddr_1[27:0] <= data_in[63:36];
            datamode_1      <= data_in[35:34];
            write_1         <= data_in[33];
            access_1        <= data_in[32];
            data_1          <= data_in[31:0];
         end
         default:
         begin
            ctrlmode_1   <= data_in[63:60];   // Header in lane 0
            dstaddr_1    <= data_in[59:28];
            datamode_1   <= data_in[27:26];
            write_1      <= data_in[25];
            access_1     <= data_in[24];
            data_1[31:8] <= data_in[23:0];
         end
      endcase
   end

   // ##############################
   // Final register and stream beats
   // ##############################
   always_ff @(posedge rx_lclk_div4 or posedge reset)
   begin
      if (reset)
      begin
         access_reg <= 1'b0;
         stream_reg <= 1'b0;
      end
      else
      begin
         if (!stream_reg)
            access_reg <= access_1 & active_1;   // Stays high across beats
         stream_reg <= stream_1;
      end
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (stream_reg)
         dec_dstaddr <= dec_dstaddr + STREAM_STEP;
      else
      begin
         dec_ctrlmode <= ctrlmode_1;
         dec_dstaddr  <= dstaddr_1;
         dec_datamode <= datamode_1;
         dec_write    <= write_1;
      end
      dec_data    <= data_1;
      dec_srcaddr <= srcaddr_1;
      case (align_1)
         3'd4: dec_srcaddr[7:0]  <= data_in[63:56];
         3'd3: dec_srcaddr[15:0] <= data_in[63:48];
         3'd2: dec_srcaddr[23:0] <= data_in[63:40];
         3'd1: dec_srcaddr       <= data_in[63:32];
         3'd0:
         begin
            dec_data[7:0] <= data_in[63:56];
            dec_srcaddr   <= data_in[55:24];
         end
         default: ;   // Lanes 7 to 5 complete in stage 1
      endcase
   end

   assign dec_access = access_reg & rx_enable_sync;

   a_frame_known: assert property (@(posedge rx_lclk_div4) disable iff (reset)
      !$isunknown(rx_frame_par));

endmodule

// ==== hdl/erx_remap.sv ====
`timescale 1ns/1ps

module erx_remap import erx_pkg::*;
(
   input  logic     rx_lclk_div4,
   input  logic     reset,
   input  logic     dec_access,
   input  logic     dec_write,
   input  dmode_t   dec_datamode,
   input  ctrl_t    dec_ctrlmode,
   input  addr_t    dec_dstaddr,
   input  data_t    dec_data,
   input  addr_t    dec_srcaddr,
   input  chip_id_t chip_id,
   input  chip_id_t remap_mask,
   input  chip_id_t remap_pattern,
   output logic     erx_access,
   output packet_t  erx_packet,
   output logic     remap_bypass
);

   chip_id_t dst_hi;
   chip_id_t dst_hi_remap;
   logic     bypass;
   addr_t    dst_out;
   packet_t  packet;

   assign dst_hi = dec_dstaddr[31:20];

   // Writes to our own chip ID are not remapped
   assign bypass       = dec_write & (dst_hi == chip_id);
   assign dst_hi_remap = (remap_pattern & remap_mask) | (dst_hi & ~remap_mask);
   assign dst_out      = bypass ? dec_dstaddr : {dst_hi_remap, dec_dstaddr[19:0]};

   // ##############################
   // Packet packing
   // ##############################
   always_comb
   begin
      packet                                    = '0;
      packet[PKT_WRITE_BIT]                     = dec_write;
      packet[PKT_DMODE_LSB +: $bits(dmode_t)]   = dec_datamode;
      packet[PKT_CTRL_LSB +: $bits(ctrl_t)]     = dec_ctrlmode;
      packet[PKT_RSVD_BIT]                      = 1'b0;
      packet[PKT_DST_LSB +: $bits(addr_t)]      = dst_out;
      packet[PKT_DATA_LSB +: $bits(data_t)]     = dec_data;
      packet[PKT_SRC_LSB +: $bits(addr_t)]      = dec_srcaddr;
   end

   always_ff @(posedge rx_lclk_div4 or posedge reset)
   begin
      if (reset)
      begin
         erx_access   <= 1'b0;
         remap_bypass <= 1'b0;
      end
      else
      begin
         erx_access   <= dec_access;
         remap_bypass <= dec_access & bypass;
      end
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (dec_access)
         erx_packet <= packet;   // Held between transactions
   end

   // Bypass decision needs known write flag and address
   a_bypass_inputs_known: assert property (@(posedge rx_lclk_div4) disable iff (reset)
      dec_access |-> !$isunknown({dec_write, dec_dstaddr}));

endmodule

// ==== hdl/erx_top.sv ====
`timescale 1ns/1ps

module erx_top import erx_pkg::*;
(
   input  logic        rx_lclk_div4,
   input  logic        reset,
   input  logic        rx_enable,
   input  lane_frame_t rx_frame_par,
   input  lane_data_t  rx_data_par,
   input  logic        cfg_write,
   input  logic [1:0]  cfg_addr,
   input  chip_id_t    cfg_data,
   output logic        erx_access,
   output packet_t     erx_packet,
   output logic        remap_bypass
);

   logic     rx_enable_sync;
   chip_id_t chip_id;
   chip_id_t remap_mask;
   chip_id_t remap_pattern;

   // Decoded transaction
   logic     dec_access;
   logic     dec_write;
   dmode_t   dec_datamode;
   ctrl_t    dec_ctrlmode;
   addr_t    dec_dstaddr;
   data_t    dec_data;
   addr_t    dec_srcaddr;

   erx_cfg i_erx_cfg (
      .rx_lclk_div4   (rx_lclk_div4),
      .reset          (reset),
      .rx_enable      (rx_enable),
      .cfg_write      (cfg_write),
      .cfg_addr       (cfg_addr),
      .cfg_data       (cfg_data),
      .rx_enable_sync (rx_enable_sync),
      .chip_id        (chip_id),
      .remap_mask     (remap_mask),
      .remap_pattern  (remap_pattern)
   );

   erx_protocol i_erx_protocol (
      .rx_lclk_div4   (rx_lclk_div4),
      .reset          (reset),
      .rx_enable_sync (rx_enable_sync),
      .rx_frame_par   (rx_frame_par),
      .rx_data_par    (rx_data_par),
      .dec_access     (dec_access),
      .dec_write      (dec_write),
      .dec_datamode   (dec_datamode),
      .dec_ctrlmode   (dec_ctrlmode),
      .dec_dstaddr    (dec_dstaddr),
      .dec_data       (dec_data),
      .dec_srcaddr    (dec_srcaddr)
   );

   erx_remap i_erx_remap (
      .rx_lclk_div4  (rx_lclk_div4),
      .reset         (reset),
      .dec_access    (dec_access),
      .dec_write     (dec_write),
      .dec_datamode  (dec_datamode),
      .dec_ctrlmode  (dec_ctrlmode),
      .dec_dstaddr   (dec_dstaddr),
      .dec_data      (dec_data),
      .dec_srcaddr   (dec_srcaddr),
      .chip_id       (chip_id),
      .remap_mask    (remap_mask),
      .remap_pattern (remap_pattern),
      .erx_access    (erx_access),
      .erx_packet    (erx_packet),
      .remap_bypass  (remap_bypass)
   );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the erx receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_erx \
   -Mdir obj_dir -o sim_erx
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_erx > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
   exit 1
fi
exit 0

// ==== verif/erx_checker.sv ====
`timescale 1ns/1ps

module erx_checker
   import erx_pkg::*;
(
   input  logic         rx_lclk_div4,
   input  logic         reset,
   input  logic         erx_access,
   input  packet_t      erx_packet,
   input  logic         remap_bypass,
   input  logic         exp_valid,
   input  packet_t      exp_packet,
   input  logic         exp_bypass,
   input  logic [127:0] exp_name,
   output int           error_count,
   output int           checked_count,
   output int           pending
);

   localparam int WAIT_LIMIT = 20;   // Cycles an expected packet may wait

   typedef struct packed
   {
      logic [127:0] name;
      packet_t      packet;
      logic         bypass;
   } expect_t;

   expect_t exp_q [$];
   expect_t head;
   int      errs;
   int      checked;
   int      age;   // Cycles the oldest entry has waited

   // Packed name to text, leading zero bytes dropped
   function automatic string name_text(input logic [127:0] name);
      string s;
      s = "";
      for (int i = 15; i >= 0; i--)
      begin
         if (name[8*i +: 8] != 8'h00)
            s = $sformatf("%s%c", s, name[8*i +: 8]);
      end
      return s;
   endfunction

   // ##############################
   // Compare in order of arrival
   // ##############################
   always @(posedge rx_lclk_div4)
   begin
      if (!reset)
      begin
         if (remap_bypass && !erx_access)
         begin
            $display("remap_bypass is high without erx_access at %0t", $time);
            errs++;
         end
         if (erx_access)
         begin
            if (exp_q.size() == 0)
            begin
               $display("Unexpected erx_access with packet %h at %0t", erx_packet, $time);
               errs++;
            end
            else
            begin
               head = exp_q.pop_front();
               checked++;
               age = 0;
               if (erx_packet !== head.packet)
               begin
                  $display("[ERROR] %s: packet expected %h, actual %h",
                           name_text(head.name), head.packet, erx_packet);
                  errs++;
               end
               if (remap_bypass !== head.bypass)
               begin
                  $display("[ERROR] %s: remap_bypass expected %b, actual %b",
                           name_text(head.name), head.bypass, remap_bypass);
                  errs++;
               end
            end
         end
         else if (exp_q.size() != 0)
         begin
            age++;
            if (age > WAIT_LIMIT)
            begin
               head = exp_q.pop_front();
               $display("No erx_access for test %s within %0d cycles",
                        name_text(head.name), WAIT_LIMIT);
               errs++;
               age = 0;
            end
         end
         if (exp_valid)
            exp_q.push_back({exp_name, exp_packet, exp_bypass});
      end
      error_count   <= errs;
      checked_count <= checked;
      pending       <= exp_q.size();
   end

endmodule

// ==== verif/tb_erx.sv ====
`timescale 1ns/1ps

module tb_erx
   import erx_pkg::*;
();

   typedef struct packed
   {
      logic [127:0] name;
      chip_id_t     chip_id;
      chip_id_t     mask;
      chip_id_t     pattern;
      logic         enable;
      align_t       lane;      // Lane of the header byte
      logic         write;
      ctrl_t        ctrl;
      dmode_t       dmode;
      addr_t        dst;
      data_t        data;
      addr_t        src;
      logic [1:0]   beats;     // Transactions in one frame
   } row_t;

   logic         rx_lclk_div4 = 1'b0;
   logic         reset;
   logic         rx_enable;
   lane_frame_t  rx_frame_par;
   lane_data_t   rx_data_par;
   logic         cfg_write;
   logic [1:0]   cfg_addr;
   chip_id_t     cfg_data;
   logic         erx_access;
   packet_t      erx_packet;
   logic         remap_bypass;

   // Expected packets into the checker
   logic         exp_valid;
   packet_t      exp_packet;
   logic         exp_bypass;
   logic [127:0] exp_name;
   int           error_count;
   int           checked_count;
   int           pending;

   row_t rows [$];
   logic timed_out;

   always #5 rx_lclk_div4 = ~rx_lclk_div4;

   erx_top i_erx_top (
      .rx_lclk_div4 (rx_lclk_div4),
      .reset        (reset),
      .rx_enable    (rx_enable),
      .rx_frame_par (rx_frame_par),
      .rx_data_par  (rx_data_par),
      .cfg_write    (cfg_write),
      .cfg_addr     (cfg_addr),
      .cfg_data     (cfg_data),
      .erx_access   (erx_access),
      .erx_packet   (erx_packet),
      .remap_bypass (remap_bypass)
   );

   erx_checker i_erx_checker (
      .rx_lclk_div4  (rx_lclk_div4),
      .reset         (reset),
      .erx_access    (erx_access),
      .erx_packet    (erx_packet),
      .remap_bypass  (remap_bypass),
      .exp_valid     (exp_valid),
      .exp_packet    (exp_packet),
      .exp_bypass    (exp_bypass),
      .exp_name      (exp_name),
      .error_count   (error_count),
      .checked_count (checked_count),
      .pending       (pending)
   );

   // ##############################
   // Expected values
   // ##############################
   function automatic data_t beat_data(input row_t rw, input int b);
      return rw.data ^ (32'(b) * 32'h1111_1111);
   endfunction

   function automatic addr_t beat_src(input row_t rw, input int b);
      return rw.src + (32'(b) * 32'h0000_0100);
   endfunction

   function automatic logic expect_bypass(input row_t rw, input addr_t dst);
      return rw.write && (dst[31:20] == rw.chip_id);
   endfunction

   function automatic packet_t expect_packet(input row_t rw, input int b);
      addr_t dst;
      dst = rw.dst + 32'(8 * b);   // Each stream beat moves 8 up
      if (!expect_bypass(rw, dst))
      begin
         for (int i = 0; i < 12; i++)
         begin
            if (rw.mask[i])
               dst[20 + i] = rw.pattern[i];   // Masked bit takes the pattern
         end
      end
      return {beat_src(rw, b), beat_data(rw, b), dst, 1'b0, rw.ctrl, rw.dmode, rw.write};
   endfunction

   task automatic add_row(input logic [127:0] name, input chip_id_t chip_id,
                          input chip_id_t mask, input chip_id_t pattern, input logic enable,
                          input align_t lane, input logic write, input ctrl_t ctrl,
                          input dmode_t dmode, input addr_t dst, input data_t data,
                          input addr_t src, input logic [1:0] beats);
      rows.push_back({name, chip_id, mask, pattern, enable, lane, write, ctrl, dmode,
                      dst, data, src, beats});
   endtask

   task automatic build_table();
      add_row("read_lane7", 12'h810, 12'hf00, 12'h300, 1'b1, 3'd7, 1'b0, 4'h3, 2'd2,
              32'h1234_5678, 32'hdead_beef, 32'h0a0b_0c0d, 2'd1);
      add_row("read_lane6", 12'h810, 12'hf00, 12'h300, 1'b1, 3'd6, 1'b0, 4'h5, 2'd1,
              32'h2345_6780, 32'h0102_0304, 32'h1111_2222, 2'd1);
      add_row("read_lane5", 12'h810, 12'hf00, 12'h300, 1'b1, 3'd5, 1'b0, 4'h9, 2'd0,
              32'h3456_7894, 32'hcafe_f00d, 32'h8899_aabb, 2'd1);
      add_row("read_lane4", 12'h810, 12'hf00, 12'h300, 1'b1, 3'd4, 1'b0, 4'hc, 2'd3,
              32'h4567_89a8, 32'h5555_aaaa, 32'h7654_3210, 2'd1);
      add_row("read_lane3", 12'h810, 12'hf00, 12'h300, 1'b1, 3'd3, 1'b0, 4'h1, 2'd2,
              32'h5678_9abc, 32'h0f0e_0d0c, 32'hfedc_ba98, 2'd1);
      add_row("read_lane2", 12'h810, 12'hf00, 12'h300, 1'b1, 3'd2, 1'b0, 4'hf, 2'd1,
              32'h6789_abc0, 32'h1357_9bdf, 32'h2468_ace0, 2'd1);
      add_row("read_lane1", 12'h810, 12'hf00, 12'h300, 1'b1, 3'd1, 1'b0, 4'h6, 2'd2,
              32'h789a_bcd4, 32'h8000_0001, 32'h0000_ffff, 2'd1);
      add_row("read_lane0", 12'h810, 12'hf00, 12'h300, 1'b1, 3'd0, 1'b0, 4'ha, 2'd3,
              32'h89ab_cde8, 32'h7fff_fffe, 32'hffff_0000, 2'd1);
      // Same write, once to our chip and once elsewhere
      add_row("write_bypass", 12'h812, 12'hfff, 12'h555, 1'b1, 3'd5, 1'b1, 4'h2, 2'd2,
              32'h8120_0040, 32'h600d_d00d, 32'h3000_0010, 2'd1);
      add_row("write_remap", 12'h813, 12'hfff, 12'h555, 1'b1, 3'd5, 1'b1, 4'h2, 2'd2,
              32'h8120_0040, 32'h600d_d00d, 32'h3000_0010, 2'd1);
      add_row("stream_lane7", 12'h810, 12'h0f0, 12'h0a0, 1'b1, 3'd7, 1'b0, 4'h4, 2'd2,
              32'h4000_0100, 32'h1000_0001, 32'h2000_0002, 2'd3);
      add_row("disabled_frame", 12'h810, 12'hf00, 12'h300, 1'b0, 3'd3, 1'b0, 4'h7, 2'd1,
              32'h9abc_def0, 32'h4242_4242, 32'h1357_2468, 2'd1);
      add_row("reenabled_frame", 12'h810, 12'hf00, 12'h300, 1'b1, 3'd3, 1'b0, 4'h7, 2'd1,
              32'h9abc_def0, 32'h4242_4242, 32'h1357_2468, 2'd1);
      add_row("remap_cfg_a", 12'h810, 12'h0ff, 12'h0c3, 1'b1, 3'd4, 1'b0, 4'hb, 2'd0,
              32'hab00_0010, 32'h0bad_cafe, 32'h0000_1234, 2'd1);
      add_row("remap_cfg_b", 12'h810, 12'hf0f, 12'ha05, 1'b1, 3'd4, 1'b0, 4'hb, 2'd0,
              32'hab00_0010, 32'h0bad_cafe, 32'h0000_1234, 2'd1);
   endtask

   // ##############################
   // Link and config drivers
   // ##############################
   task automatic idle_groups(input int n);
      repeat (n)
      begin
         @(posedge rx_lclk_div4);
         rx_frame_par <= '0;
         rx_data_par  <= {$urandom, $urandom};   // Idle lanes carry noise
      end
   endtask

   task automatic write_cfg(input logic [1:0] addr, input chip_id_t value);
      @(posedge rx_lclk_div4);
      cfg_write <= 1'b1;
      cfg_addr  <= addr;
      cfg_data  <= value;
   endtask

   task automatic push_expected(input row_t rw);
      addr_t dst;
      for (int b = 0; b < int'(rw.beats); b++)
      begin
         dst = rw.dst + 32'(8 * b);
         @(posedge rx_lclk_div4);
         exp_valid  <= 1'b1;
         exp_packet <= expect_packet(rw, b);
         exp_bypass <= expect_bypass(rw, dst);
         exp_name   <= rw.name;
      end
      @(posedge rx_lclk_div4);
      exp_valid <= 1'b0;
   endtask

   // Lay the frame bytes out from lane 7 of the first group onward
   task automatic drive_frame(input row_t rw);
      logic [7:0]  fbytes [$];
      lane_frame_t frame;
      lane_data_t  data;
      data_t       bd;
      addr_t       bs;
      int          offset;
      int          ngroups;
      int          k;
      offset = 7 - int'(rw.lane);   // Byte slots ahead of the header
      fbytes.push_back(8'($urandom));   // Header byte
      fbytes.push_back({rw.ctrl, rw.dst[31:28]});
      fbytes.push_back(rw.dst[27:20]);
      fbytes.push_back(rw.dst[19:12]);
      fbytes.push_back(rw.dst[11:4]);
      fbytes.push_back({rw.dst[3:0], rw.dmode, rw.write, 1'b1});
      for (int b = 0; b < int'(rw.beats); b++)
      begin
         bd = beat_data(rw, b);
         bs = beat_src(rw, b);
         for (int i = 3; i >= 0; i--)
            fbytes.push_back(bd[8*i +: 8]);
         for (int i = 3; i >= 0; i--)
            fbytes.push_back(bs[8*i +: 8]);
      end
      ngroups = (offset + fbytes.size() + 7) / 8;
      for (int g = 0; g < ngroups; g++)
      begin
         for (int j = 7; j >= 0; j--)
         begin
            k = 8 * g + (7 - j) - offset;
            if (k >= 0 && k < fbytes.size())
            begin
               frame[j]       = 1'b1;
               data[8*j +: 8] = fbytes[k];
            end
            else
            begin
               frame[j]       = 1'b0;
               data[8*j +: 8] = 8'($urandom);
            end
         end
         @(posedge rx_lclk_div4);
         rx_frame_par <= frame;
         rx_data_par  <= data;
      end
   endtask

   task automatic run_row(input row_t rw, output logic late);
      int waited;
      late = 1'b0;
      @(posedge rx_lclk_div4);
      rx_enable <= rw.enable;
      write_cfg(CFG_CHIP_ID, rw.chip_id);
      write_cfg(CFG_REMAP_MASK, rw.mask);
      write_cfg(CFG_REMAP_PATTERN, rw.pattern);
      write_cfg(2'd3, 12'hfff);   // Unmapped address
      @(posedge rx_lclk_div4);
      cfg_write <= 1'b0;
      idle_groups(4);   // Enable synchronizer settles
      if (rw.enable)
         push_expected(rw);
      drive_frame(rw);
      waited = 0;
      while (pending != 0 && waited < 20)
      begin
         idle_groups(1);
         waited++;
      end
      late = (pending != 0);
      idle_groups(4);
   endtask

   // ##############################
   // Main sequence
   // ##############################
   initial
   begin
      reset        <= 1'b1;
      rx_enable    <= 1'b0;
      rx_frame_par <= '0;
      rx_data_par  <= '0;
      cfg_write    <= 1'b0;
      cfg_addr     <= '0;
      cfg_data     <= '0;
      exp_valid    <= 1'b0;
      exp_packet   <= '0;
      exp_bypass   <= 1'b0;
      exp_name     <= '0;
      timed_out    = 1'b0;
      void'($urandom(29));
      build_table();
      repeat (5) @(posedge rx_lclk_div4);
      reset <= 1'b0;
      idle_groups(10);   // Quiet link, nothing may come out
      for (int r = 0; r < rows.size(); r++)
      begin
         run_row(rows[r], timed_out);
         if (timed_out)
         begin
            $display("Timeout: row %0d still waits for %0d packets", r, pending);
            break;
         end
      end
      idle_groups(5);
      $display("Checked %0d packets, %0d errors", checked_count, error_count);
      if (error_count == 0 && !timed_out)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule
